// ==== logic/rdma_req_pkg.sv ====
/*
 * Widths, opcodes and payload structs shared by the RDMA request front end.
 * Opcodes are the low five bits of the RC opcodes and are used only inside this block.
 * The local buffer length of a descriptor is carried but never read.
 */
package rdma_req_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int VADDR_BITS = 48;
    localparam int LEN_BITS   = 28;
    localparam int PID_BITS   = 6;
    localparam int DEST_BITS  = 4;
    localparam int OPC_BITS   = 5;
    localparam int STRM_BITS  = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [OPC_BITS-1:0] OPC_WR_FIRST  = 5'h06;
    localparam logic [OPC_BITS-1:0] OPC_WR_MIDDLE = 5'h07;
    localparam logic [OPC_BITS-1:0] OPC_WR_LAST   = 5'h08;
    localparam logic [OPC_BITS-1:0] OPC_WR_ONLY   = 5'h0a;
    localparam logic [OPC_BITS-1:0] OPC_RD_REQ    = 5'h0c;

    ////////////////////////////////////////////////////////////////////////////
    // Payloads
    ////////////////////////////////////////////////////////////////////////////

    // One side of a transfer, 90 bits
    typedef struct packed {
        logic [VADDR_BITS-1:0] vaddr;
        logic [LEN_BITS-1:0]   len;
        logic [PID_BITS-1:0]   pid;
        logic [DEST_BITS-1:0]  dest;
        logic [STRM_BITS-1:0]  strm;
        logic                  host;
        logic                  last;
    } buf_t;

    // Host descriptor, transfer length taken from the remote side
    typedef struct packed {
        buf_t rem;
        buf_t loc;
    } dreq_t;

    // Outgoing command
    typedef struct packed {
        logic [OPC_BITS-1:0]   opcode;
        logic [PID_BITS-1:0]   pid;
        logic [DEST_BITS-1:0]  dest;
        logic [VADDR_BITS-1:0] rvaddr;
        logic [VADDR_BITS-1:0] lvaddr;
        logic [LEN_BITS-1:0]   len;
        // Final command of a descriptor that had last set
        logic                  last;
        // 0 read, 1 write
        logic                  src;
    } cmd_t;

endpackage

// ==== logic/meta_reg.sv ====
/*
 * One-entry register slice on a valid/ready link, one item per cycle.
 * Latency is one cycle. s_ready is low only when full and not drained.
 */
`timescale 1ns/1ps

module meta_reg #(
    parameter type T = logic
) (
    input  logic aclk,
    input  logic aresetn,

    input  logic s_valid,
    output logic s_ready,
    input  T     s_data,

    output logic m_valid,
    input  logic m_ready,
    output T     m_data
);

    logic valid_c;
    T     data_c;

    // Free when empty or when the held item leaves this cycle
    assign s_ready = !valid_c || m_ready;

    // Occupancy
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_c <= 1'b0;
        end else if (s_ready) begin
            valid_c <= s_valid;
        end
    end

    // Payload, loaded on input handshake only
    always_ff @(posedge aclk) begin
        if (s_valid && s_ready) begin
            data_c <= s_data;
        end
    end

    assign m_valid = valid_c;
    assign m_data  = data_c;

endmodule

// ==== logic/rdma_rd_splitter.sv ====
/*
 * Cuts one read descriptor into read commands of at most MAX_READ_BYTES.
 * One command every two cycles at best; s_ready stays low until the last one is sent.
 * A zero length read still yields one command of length 0.
 */
`timescale 1ns/1ps

module rdma_rd_splitter #(
    parameter int MAX_READ_BYTES = 4096
) (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                s_valid,
    output logic                s_ready,
    input  rdma_req_pkg::dreq_t s_req,

    output logic                m_valid,
    input  logic                m_ready,
    output rdma_req_pkg::cmd_t  m_cmd
);
    import rdma_req_pkg::*;

    localparam logic [LEN_BITS-1:0]   MAX_LEN = LEN_BITS'(MAX_READ_BYTES);
    localparam logic [VADDR_BITS-1:0] MAX_VA  = VADDR_BITS'(MAX_READ_BYTES);

    typedef enum logic [1:0] {ST_IDLE, ST_PARSE, ST_SEND} state_t;
    state_t state_c, state_n;

    // Remaining part of the descriptor
    dreq_t req_c, req_n;

    // Chunk being sent
    logic [VADDR_BITS-1:0] prvaddr_c, prvaddr_n;
    logic [VADDR_BITS-1:0] plvaddr_c, plvaddr_n;
    logic [LEN_BITS-1:0]   plen_c, plen_n;
    logic                  plast_c, plast_n;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_c <= ST_IDLE;
        end else begin
            state_c <= state_n;
        end
    end

    always_ff @(posedge aclk) begin
        req_c     <= req_n;
        prvaddr_c <= prvaddr_n;
        plvaddr_c <= plvaddr_n;
        plen_c    <= plen_n;
        plast_c   <= plast_n;
    end

    always_comb begin
        state_n   = state_c;
        req_n     = req_c;
        prvaddr_n = prvaddr_c;
        plvaddr_n = plvaddr_c;
        plen_n    = plen_c;
        plast_n   = plast_c;
        s_ready   = 1'b0;
        m_valid   = 1'b0;

        case (state_c)
            ST_IDLE: begin
                s_ready = 1'b1;
                if (s_valid) begin
                    req_n   = s_req;
                    state_n = ST_PARSE;
                end
            end

            // Carve off the next chunk
            ST_PARSE: begin
                prvaddr_n = req_c.rem.vaddr;
                plvaddr_n = req_c.loc.vaddr;
                if (req_c.rem.len > MAX_LEN) begin
                    req_n.rem.vaddr = req_c.rem.vaddr + MAX_VA;
                    req_n.loc.vaddr = req_c.loc.vaddr + MAX_VA;
                    req_n.rem.len   = req_c.rem.len - MAX_LEN;
                    plen_n          = MAX_LEN;
                    plast_n         = 1'b0;
                end else begin
                    // Tail, descriptor is done after this one
                    req_n.rem.len = '0;
                    plen_n        = req_c.rem.len;
                    plast_n       = req_c.rem.last;
                end
                state_n = ST_SEND;
            end

            ST_SEND: begin
                m_valid = 1'b1;
                if (m_ready) begin
                    state_n = (req_c.rem.len != '0) ? ST_PARSE : ST_IDLE;
                end
            end

            default: state_n = ST_IDLE;
        endcase
    end

    // Command fields, src is filled in by the arbiter
    always_comb begin
        m_cmd        = '0;
        m_cmd.opcode = OPC_RD_REQ;
        m_cmd.pid    = req_c.rem.pid;
        m_cmd.dest   = req_c.rem.dest;
        m_cmd.rvaddr = prvaddr_c;
        m_cmd.lvaddr = plvaddr_c;
        m_cmd.len    = plen_c;
        m_cmd.last   = plast_c;
    end

endmodule

// ==== logic/rdma_wr_splitter.sv ====
/*
 * Cuts one write descriptor into packets of at most PMTU_BYTES, labelled by position.
 * One packet every two cycles at best; s_ready stays low until the last one is sent.
 * A zero length write yields one ONLY packet of length 0.
 */
`timescale 1ns/1ps

module rdma_wr_splitter #(
    parameter int PMTU_BYTES = 1024
) (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                s_valid,
    output logic                s_ready,
    input  rdma_req_pkg::dreq_t s_req,

    output logic                m_valid,
    input  logic                m_ready,
    output rdma_req_pkg::cmd_t  m_cmd
);
    import rdma_req_pkg::*;

    localparam logic [LEN_BITS-1:0]   PMTU_LEN = LEN_BITS'(PMTU_BYTES);
    localparam logic [VADDR_BITS-1:0] PMTU_VA  = VADDR_BITS'(PMTU_BYTES);

    typedef enum logic [1:0] {ST_IDLE, ST_PARSE, ST_SEND} state_t;
    state_t state_c, state_n;

    dreq_t req_c, req_n;

    // Set until the first packet has been carved
    logic first_c, first_n;

    // Packet being sent
    logic [OPC_BITS-1:0]   popc_c, popc_n;
    logic [VADDR_BITS-1:0] prvaddr_c, prvaddr_n;
    logic [VADDR_BITS-1:0] plvaddr_c, plvaddr_n;
    logic [LEN_BITS-1:0]   plen_c, plen_n;
    logic                  plast_c, plast_n;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state_c <= ST_IDLE;
        end else begin
            state_c <= state_n;
        end
    end

    always_ff @(posedge aclk) begin
        req_c     <= req_n;
        first_c   <= first_n;
        popc_c    <= popc_n;
        prvaddr_c <= prvaddr_n;
        plvaddr_c <= plvaddr_n;
        plen_c    <= plen_n;
        plast_c   <= plast_n;
    end

    always_comb begin
        state_n   = state_c;
        req_n     = req_c;
        first_n   = first_c;
        popc_n    = popc_c;
        prvaddr_n = prvaddr_c;
        plvaddr_n = plvaddr_c;
        plen_n    = plen_c;
        plast_n   = plast_c;
        s_ready   = 1'b0;
        m_valid   = 1'b0;

        case (state_c)
            ST_IDLE: begin
                s_ready = 1'b1;
                if (s_valid) begin
                    req_n   = s_req;
                    first_n = 1'b1;
                    state_n = ST_PARSE;
                end
            end

            ST_PARSE: begin
                prvaddr_n = req_c.rem.vaddr;
                plvaddr_n = req_c.loc.vaddr;
                first_n   = 1'b0;
                if (req_c.rem.len > PMTU_LEN) begin
                    // More packets follow
                    req_n.rem.vaddr = req_c.rem.vaddr + PMTU_VA;
                    req_n.loc.vaddr = req_c.loc.vaddr + PMTU_VA;
                    req_n.rem.len   = req_c.rem.len - PMTU_LEN;
                    popc_n          = first_c ? OPC_WR_FIRST : OPC_WR_MIDDLE;
                    plen_n          = PMTU_LEN;
                    plast_n         = 1'b0;
                end else begin
                    // Closing packet
                    req_n.rem.len = '0;
                    popc_n        = first_c ? OPC_WR_ONLY : OPC_WR_LAST;
                    plen_n        = req_c.rem.len;
                    plast_n       = req_c.rem.last;
                end
                state_n = ST_SEND;
            end

            ST_SEND: begin
                m_valid = 1'b1;
                if (m_ready) begin
                    state_n = (req_c.rem.len != '0) ? ST_PARSE : ST_IDLE;
                end
            end

            default: state_n = ST_IDLE;
        endcase
    end

    always_comb begin
        m_cmd        = '0;
        m_cmd.opcode = popc_c;
        m_cmd.pid    = req_c.rem.pid;
        m_cmd.dest   = req_c.rem.dest;
        m_cmd.rvaddr = prvaddr_c;
        m_cmd.lvaddr = plvaddr_c;
        m_cmd.len    = plen_c;
        m_cmd.last   = plast_c;
    end

endmodule

// ==== logic/cmd_arbiter.sv ====
/*
 * Round-robin merge of the read and write command streams onto one bus.
 * Output is combinational from the granted input. The grant holds under back-pressure.
 */
`timescale 1ns/1ps

module cmd_arbiter (
    input  logic               aclk,
    input  logic               aresetn,

    input  logic               s_rd_valid,
    output logic               s_rd_ready,
    input  rdma_req_pkg::cmd_t s_rd_cmd,

    input  logic               s_wr_valid,
    output logic               s_wr_ready,
    input  rdma_req_pkg::cmd_t s_wr_cmd,

    output logic               m_valid,
    input  logic               m_ready,
    output rdma_req_pkg::cmd_t m_cmd
);
    import rdma_req_pkg::*;

    // Preferred input when both request, 0 read, 1 write
    logic prio_c;
    // Held grant while a command waits on m_ready
    logic lock_c;
    logic gnt_c;
    // Grant this cycle
    logic gnt;

    always_comb begin
        if (lock_c) begin
            gnt = gnt_c;
        end else if (s_rd_valid && s_wr_valid) begin
            gnt = prio_c;
        end else begin
            gnt = s_wr_valid;
        end
    end

    // Mux the granted input through
    always_comb begin
        m_valid   = gnt ? s_wr_valid : s_rd_valid;
        m_cmd     = gnt ? s_wr_cmd : s_rd_cmd;
        m_cmd.src = gnt;
    end

    assign s_rd_ready = m_ready && !gnt;
    assign s_wr_ready = m_ready && gnt;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            prio_c <= 1'b0;
            lock_c <= 1'b0;
            gnt_c  <= 1'b0;
        end else begin
            lock_c <= m_valid && !m_ready;
            gnt_c  <= gnt;
            // Hand priority to the other side after each transfer
            if (m_valid && m_ready) begin
                prio_c <= !gnt;
            end
        end
    end

endmodule

// ==== logic/rdma_req.sv ====
/*
 * RDMA request front end: read and write descriptors in, one command stream out.
 * Minimum latency from descriptor to first command is 4 cycles.
 * Only one descriptor per direction is split at a time.
 */
`timescale 1ns/1ps

module rdma_req #(
    parameter int MAX_READ_BYTES = 4096,
    parameter int PMTU_BYTES     = 1024
) (
    input  logic                aclk,
    input  logic                aresetn,

    // Read descriptors
    input  logic                s_rd_valid,
    output logic                s_rd_ready,
    input  rdma_req_pkg::dreq_t s_rd_req,

    // Write descriptors
    input  logic                s_wr_valid,
    output logic                s_wr_ready,
    input  rdma_req_pkg::dreq_t s_wr_req,

    // Merged commands
    output logic                m_valid,
    input  logic                m_ready,
    output rdma_req_pkg::cmd_t  m_cmd
);
    import rdma_req_pkg::*;

    // Slice to splitter
    logic  rd_req_valid, rd_req_ready;
    dreq_t rd_req;
    logic  wr_req_valid, wr_req_ready;
    dreq_t wr_req;

    // Splitter to arbiter
    logic  rd_cmd_valid, rd_cmd_ready;
    cmd_t  rd_cmd;
    logic  wr_cmd_valid, wr_cmd_ready;
    cmd_t  wr_cmd;

    // Arbiter to output slice
    logic  arb_valid, arb_ready;
    cmd_t  arb_cmd;

    ////////////////////////////////////////////////////////////////////////////
    // Input slices
    ////////////////////////////////////////////////////////////////////////////
    meta_reg #(.T(dreq_t)) inst_rd_in (
        .aclk(aclk), .aresetn(aresetn),
        .s_valid(s_rd_valid), .s_ready(s_rd_ready), .s_data(s_rd_req),
        .m_valid(rd_req_valid), .m_ready(rd_req_ready), .m_data(rd_req)
    );

    meta_reg #(.T(dreq_t)) inst_wr_in (
        .aclk(aclk), .aresetn(aresetn),
        .s_valid(s_wr_valid), .s_ready(s_wr_ready), .s_data(s_wr_req),
        .m_valid(wr_req_valid), .m_ready(wr_req_ready), .m_data(wr_req)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Splitters
    ////////////////////////////////////////////////////////////////////////////
    rdma_rd_splitter #(.MAX_READ_BYTES(MAX_READ_BYTES)) inst_rd_split (
        .aclk(aclk), .aresetn(aresetn),
        .s_valid(rd_req_valid), .s_ready(rd_req_ready), .s_req(rd_req),
        .m_valid(rd_cmd_valid), .m_ready(rd_cmd_ready), .m_cmd(rd_cmd)
    );

    rdma_wr_splitter #(.PMTU_BYTES(PMTU_BYTES)) inst_wr_split (
        .aclk(aclk), .aresetn(aresetn),
        .s_valid(wr_req_valid), .s_ready(wr_req_ready), .s_req(wr_req),
        .m_valid(wr_cmd_valid), .m_ready(wr_cmd_ready), .m_cmd(wr_cmd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Merge and output slice
    ////////////////////////////////////////////////////////////////////////////
    cmd_arbiter inst_arb (
        .aclk(aclk), .aresetn(aresetn),
        .s_rd_valid(rd_cmd_valid), .s_rd_ready(rd_cmd_ready), .s_rd_cmd(rd_cmd),
        .s_wr_valid(wr_cmd_valid), .s_wr_ready(wr_cmd_ready), .s_wr_cmd(wr_cmd),
        .m_valid(arb_valid), .m_ready(arb_ready), .m_cmd(arb_cmd)
    );

    // Cuts the combinational path from the arbiter mux
    meta_reg #(.T(cmd_t)) inst_out (
        .aclk(aclk), .aresetn(aresetn),
        .s_valid(arb_valid), .s_ready(arb_ready), .s_data(arb_cmd),
        .m_valid(m_valid), .m_ready(m_ready), .m_data(m_cmd)
    );

endmodule

// ==== sim/tb_clkgen.sv ====
/*
 * Testbench clock and reset source, 8 ns period.
 * Reset is low for RESET_CYCLES rising edges and released on a falling edge.
 */
`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic aclk,
    output logic aresetn
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2.0) aclk = ~aclk;
    end

    // Release away from the sampling edge
    initial begin
        aresetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
    end

endmodule

// ==== sim/tb_rdma_req.sv ====
/*
 * Random read and write descriptors with lengths 0 to 300, random gaps and m_ready.
 * The first descriptors of each side get fixed corner lengths (zero, exact chunk multiples).
 * Expected commands come from a model of the split rules, one queue per source.
 * Arbiter fairness is observed on the DUT's internal splitter to arbiter links.
 */
`timescale 1ns/1ps

module tb_rdma_req;
    import rdma_req_pkg::*;

    localparam int          MAX_READ_BYTES = 64;
    localparam int          PMTU_BYTES     = 32;
    localparam int          N_DESC         = 40;
    localparam logic [31:0] SEED           = 32'h8c24_a2ef;

    logic  aclk;
    logic  aresetn;
    logic  s_rd_valid;
    logic  s_rd_ready;
    dreq_t s_rd_req;
    logic  s_wr_valid;
    logic  s_wr_ready;
    dreq_t s_wr_req;
    logic  m_valid;
    logic  m_ready;
    cmd_t  m_cmd;

    // Stimulus and model state
    logic [31:0] lfsr;
    dreq_t       rd_desc [N_DESC];
    dreq_t       wr_desc [N_DESC];
    int          rd_idx;
    int          wr_idx;
    int          limit_cycles;
    cmd_t        rd_q [$];
    cmd_t        wr_q [$];
    // Handshake seen on the last rising edge
    logic        rd_fired;
    logic        wr_fired;

    // Monitor state
    logic        rst_d;
    logic        hold_pending;
    cmd_t        held_cmd;
    int          rd_skips;
    int          wr_skips;

    tb_clkgen #(.PERIOD_NS(8.0), .RESET_CYCLES(10)) inst_clk (
        .aclk(aclk), .aresetn(aresetn)
    );

    rdma_req #(.MAX_READ_BYTES(MAX_READ_BYTES), .PMTU_BYTES(PMTU_BYTES)) UUT (
        .aclk(aclk), .aresetn(aresetn),
        .s_rd_valid(s_rd_valid), .s_rd_ready(s_rd_ready), .s_rd_req(s_rd_req),
        .s_wr_valid(s_wr_valid), .s_wr_ready(s_wr_ready), .s_wr_req(s_wr_req),
        .m_valid(m_valid), .m_ready(m_ready), .m_cmd(m_cmd)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Error exits
    ////////////////////////////////////////////////////////////////////////////
    task automatic mismatch_fatal(input string name, input logic [191:0] got,
                                  input logic [191:0] exp);
        $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////////////////////////////////
    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [47:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[46:0], lfsr[0]};
        end
    endtask

    task automatic make_desc(output dreq_t d);
        logic [47:0] v;
        take_bits(9, v);
        d.rem.len = LEN_BITS'(v % 301);
        take_bits(48, v);
        d.rem.vaddr = v;
        take_bits(48, v);
        d.loc.vaddr = v;
        take_bits(24, v);
        d.rem.pid  = v[5:0];
        d.rem.dest = v[9:6];
        d.rem.strm = v[11:10];
        d.rem.host = v[12];
        d.rem.last = v[13];
        // Local side is carried but must not matter
        d.loc.len  = LEN_BITS'(v[23:14]);
        d.loc.pid  = v[5:0] ^ 6'h15;
        d.loc.dest = v[9:6];
        d.loc.strm = v[11:10];
        d.loc.host = v[13];
        d.loc.last = v[12];
    endtask

    // Commands per descriptor
    // A zero length still gives one
    function automatic int count_cmds(input int len, input int cs);
        return (len == 0) ? 1 : (len + cs - 1) / cs;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    task automatic expand_desc(input dreq_t d, input logic is_wr);
        cmd_t                c;
        logic [LEN_BITS-1:0] left;
        logic [LEN_BITS-1:0] cs;
        logic                first;
        logic                done;
        left     = d.rem.len;
        cs       = is_wr ? LEN_BITS'(PMTU_BYTES) : LEN_BITS'(MAX_READ_BYTES);
        first    = 1'b1;
        done     = 1'b0;
        c        = '0;
        c.pid    = d.rem.pid;
        c.dest   = d.rem.dest;
        c.src    = is_wr;
        c.rvaddr = d.rem.vaddr;
        c.lvaddr = d.loc.vaddr;
        while (!done) begin
            if (left > cs) begin
                c.len    = cs;
                c.last   = 1'b0;
                c.opcode = !is_wr ? OPC_RD_REQ : (first ? OPC_WR_FIRST : OPC_WR_MIDDLE);
            end else begin
                // Tail chunk carries the descriptor's last
                c.len    = left;
                c.last   = d.rem.last;
                c.opcode = !is_wr ? OPC_RD_REQ : (first ? OPC_WR_ONLY : OPC_WR_LAST);
                done     = 1'b1;
            end
            if (is_wr) begin
                wr_q.push_back(c);
            end else begin
                rd_q.push_back(c);
            end
            c.rvaddr = c.rvaddr + cs;
            c.lvaddr = c.lvaddr + cs;
            left     = left - c.len;
            first    = 1'b0;
        end
    endtask

    task automatic compare_cmd(input cmd_t exp);
        assert (m_cmd.opcode == exp.opcode)
            else mismatch_fatal("m_cmd.opcode", m_cmd.opcode, exp.opcode);
        assert (m_cmd.pid == exp.pid) else mismatch_fatal("m_cmd.pid", m_cmd.pid, exp.pid);
        assert (m_cmd.dest == exp.dest) else mismatch_fatal("m_cmd.dest", m_cmd.dest, exp.dest);
        assert (m_cmd.rvaddr == exp.rvaddr)
            else mismatch_fatal("m_cmd.rvaddr", m_cmd.rvaddr, exp.rvaddr);
        assert (m_cmd.lvaddr == exp.lvaddr)
            else mismatch_fatal("m_cmd.lvaddr", m_cmd.lvaddr, exp.lvaddr);
        assert (m_cmd.len == exp.len) else mismatch_fatal("m_cmd.len", m_cmd.len, exp.len);
        assert (m_cmd.last == exp.last) else mismatch_fatal("m_cmd.last", m_cmd.last, exp.last);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitor sampled on the rising edge
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst_d        = 1'b1;
        hold_pending = 1'b0;
        rd_skips     = 0;
        wr_skips     = 0;
    end

    always @(posedge aclk) begin
        // Reset and the cycle after it keep m_valid low
        if (!rst_d) begin
            assert (!m_valid) else abort_run("m_valid high during or right after reset");
        end
        rst_d    = aresetn;
        rd_fired = aresetn && s_rd_valid && s_rd_ready;
        wr_fired = aresetn && s_wr_valid && s_wr_ready;
        if (rd_fired) begin
            expand_desc(s_rd_req, 1'b0);
        end
        if (wr_fired) begin
            expand_desc(s_wr_req, 1'b1);
        end

        if (aresetn && m_valid && m_ready) begin
            if (m_cmd.src) begin
                assert (wr_q.size() > 0) else abort_run("write command with none expected");
                if (wr_q.size() > 0) begin
                    compare_cmd(wr_q.pop_front());
                end
            end else begin
                assert (rd_q.size() > 0) else abort_run("read command with none expected");
                if (rd_q.size() > 0) begin
                    compare_cmd(rd_q.pop_front());
                end
            end
        end

        // Held command under back-pressure
        if (aresetn && hold_pending) begin
            assert (m_valid) else abort_run("m_valid dropped before its handshake");
            assert (m_cmd == held_cmd) else mismatch_fatal("m_cmd", m_cmd, held_cmd);
        end
        hold_pending = aresetn && m_valid && !m_ready;
        held_cmd     = m_cmd;

        // Fairness counts grants to the other side while one side waits
        if (aresetn && UUT.rd_cmd_valid && UUT.rd_cmd_ready) begin
            rd_skips = 0;
            wr_skips = UUT.wr_cmd_valid ? wr_skips + 1 : 0;
        end
        if (aresetn && UUT.wr_cmd_valid && UUT.wr_cmd_ready) begin
            wr_skips = 0;
            rd_skips = UUT.rd_cmd_valid ? rd_skips + 1 : 0;
        end
        assert (rd_skips <= 1) else abort_run("read source starved by the arbiter");
        assert (wr_skips <= 1) else abort_run("write source starved by the arbiter");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus driven on the falling edge
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic [47:0] r;
        int          total;
        s_rd_valid   = 1'b0;
        s_rd_req     = '0;
        s_wr_valid   = 1'b0;
        s_wr_req     = '0;
        m_ready      = 1'b0;
        rd_fired     = 1'b0;
        wr_fired     = 1'b0;
        rd_idx       = 0;
        wr_idx       = 0;
        limit_cycles = 0;
        lfsr         = SEED;
        total        = 0;
        for (int i = 0; i < N_DESC; i++) begin
            make_desc(rd_desc[i]);
            make_desc(wr_desc[i]);
        end
        // Zero length and exact chunk multiples are rare in the random draw
        rd_desc[0].rem.len = '0;
        wr_desc[0].rem.len = '0;
        rd_desc[1].rem.len = LEN_BITS'(2 * MAX_READ_BYTES);
        rd_desc[2].rem.len = LEN_BITS'(MAX_READ_BYTES);
        wr_desc[1].rem.len = LEN_BITS'(PMTU_BYTES);
        wr_desc[2].rem.len = LEN_BITS'(3 * PMTU_BYTES);
        for (int i = 0; i < N_DESC; i++) begin
            total += count_cmds(int'(rd_desc[i].rem.len), MAX_READ_BYTES);
            total += count_cmds(int'(wr_desc[i].rem.len), PMTU_BYTES);
        end
        limit_cycles = total * 20 + 2000;

        wait (aresetn);
        while (!(rd_idx == N_DESC && wr_idx == N_DESC && rd_q.size() == 0 &&
                 wr_q.size() == 0)) begin
            @(negedge aclk);
            if (s_rd_valid && rd_fired) begin
                s_rd_valid = 1'b0;
                rd_idx++;
            end
            if (!s_rd_valid && rd_idx < N_DESC) begin
                take_bits(2, r);
                if (r[1:0] != 2'b00) begin
                    s_rd_valid = 1'b1;
                    s_rd_req   = rd_desc[rd_idx];
                end
            end
            if (s_wr_valid && wr_fired) begin
                s_wr_valid = 1'b0;
                wr_idx++;
            end
            if (!s_wr_valid && wr_idx < N_DESC) begin
                take_bits(2, r);
                if (r[1:0] != 2'b00) begin
                    s_wr_valid = 1'b1;
                    s_wr_req   = wr_desc[wr_idx];
                end
            end
            // About one cycle in four stalled
            take_bits(2, r);
            m_ready = (r[1:0] != 2'b00);
        end

        // Quiet tail where any extra command hits an empty queue
        m_ready = 1'b1;
        repeat (20) @(negedge aclk);
        if (rd_q.size() == 0 && wr_q.size() == 0 && !m_valid) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("commands left over at end of run");
        end
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge aclk);
        abort_run("timeout, DUT stopped producing expected commands");
    end

endmodule

// ==== rdma_req.f ====
logic/rdma_req_pkg.sv
logic/meta_reg.sv
logic/rdma_rd_splitter.sv
logic/rdma_wr_splitter.sv
logic/cmd_arbiter.sv
logic/rdma_req.sv
sim/tb_clkgen.sv
sim/tb_rdma_req.sv
